// ==== source/glbl_reg_pkg.sv ====
package glbl_reg_pkg;

   // ------------------------------
   // Bus widths and word types
   // ------------------------------
   localparam int DATA_W = 32;
   localparam int ADDR_W = 5;
   localparam int BE_W   = 4;

   typedef logic [DATA_W-1:0] reg_word_t;
   typedef logic [BE_W-1:0]   reg_be_t;

   // ------------------------------
   // Register map
   // ------------------------------
   // Addresses not listed read zero and ignore writes
   typedef enum logic [ADDR_W-1:0] {
      REG_CHIP_ID   = 5'd0,
      REG_RST_CTRL  = 5'd1,
      REG_GLBL_CFG  = 5'd2,
      REG_INTR_MASK = 5'd3,
      REG_INTR_STAT = 5'd4,
      REG_MUX_SEL   = 5'd5,
      REG_RANDOM    = 5'd9,
      REG_INTR_SET  = 5'd10,
      REG_MAILBOX   = 5'd15,
      REG_SOFT_0    = 5'd16,
      REG_SOFT_1    = 5'd17,
      REG_SOFT_2    = 5'd18,
      REG_SOFT_3    = 5'd19,
      REG_SOFT_4    = 5'd20,
      REG_SOFT_5    = 5'd21,
      REG_SOFT_6    = 5'd22,
      REG_SOFT_7    = 5'd23
   } reg_addr_e;

   // ------------------------------
   // Chip identity
   // ------------------------------
   // Manufacturer code is decimal R and D
   localparam logic [15:0] MANU_CODE    = 16'h8268;
   localparam logic [3:0]  CORE_COUNT   = 4'h1;
   localparam logic [3:0]  CHIP_NUM     = 4'h6;
   localparam logic [7:0]  CHIP_REV     = 8'h01;
   localparam reg_word_t   CHIP_ID_WORD = {MANU_CODE, CORE_COUNT, CHIP_NUM, CHIP_REV};

   // ------------------------------
   // Reset defaults
   // ------------------------------
   // Boot strap high also releases core 0
   localparam reg_word_t RST_CTRL_BOOT   = 32'h0000_0103;
   localparam reg_word_t RST_CTRL_HOLD   = 32'h0000_0003;
   // UART master and RISC-V TAP enabled at power up
   localparam reg_word_t MUX_SEL_DEFAULT = 32'hC000_0000;

   // Random generator seed and Galois taps
   localparam reg_word_t LFSR_SEED = 32'h0000_0001;
   localparam reg_word_t LFSR_TAPS = 32'h8020_0003;

   // Status bits 3, 4, 6 and 7 come from other clock domains
   localparam reg_word_t SYNC_INTR_MASK = 32'h0000_00D8;

   // Byte enables widened to a bit mask
   function automatic reg_word_t be_mask(input reg_be_t be);
      reg_word_t m;
      for (int b = 0; b < BE_W; b++) begin
         m[8*b +: 8] = {8{be[b]}};
      end
      return m;
   endfunction

endpackage

// ==== source/reg_access_if.sv ====
interface reg_access_if;

   // One decoded bus access
   // Access pulse lasts a single mclk cycle
   logic                    access;
   logic                    wr;
   glbl_reg_pkg::reg_addr_e addr;
   glbl_reg_pkg::reg_word_t wdata;
   glbl_reg_pkg::reg_be_t   be;

   // Bus decoder side
   modport decoder (
      output access,
      output wr,
      output addr,
      output wdata,
      output be
   );

   // Register and read blocks
   modport target (
      input access,
      input wr,
      input addr,
      input wdata,
      input be
   );

endinterface

// ==== source/glbl_bus_decode.sv ====
module glbl_bus_decode (
   input  logic                            mclk,
   input  logic                            s_reset_n,
   input  logic                            reg_cs,
   input  logic                            reg_wr,
   input  logic [glbl_reg_pkg::ADDR_W-1:0] reg_addr,
   input  glbl_reg_pkg::reg_word_t         reg_wdata,
   input  glbl_reg_pkg::reg_be_t           reg_be,
   output logic                            reg_ack,
   reg_access_if.decoder                   acc
);

   logic start;

   // ------------------------------
   // Access pulse and acknowledge
   // ------------------------------
   // New access only while ack is low
   // Master holding cs gets one access every other cycle
   assign start = reg_cs & ~reg_ack;

   // Ack one cycle after cs is sampled
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         reg_ack <= 1'b0;
      end else begin
         reg_ack <= start;
      end
   end

   // ------------------------------
   // Forward the decoded access
   // ------------------------------
   assign acc.access = start;
   assign acc.wr     = reg_wr;
   // Raw address into the register map type
   assign acc.addr   = glbl_reg_pkg::reg_addr_e'(reg_addr);
   assign acc.wdata  = reg_wdata;
   assign acc.be     = reg_be;

   // Bus control lines known whenever cs is high
   cs_ctrl_known: assert property (
      @(posedge mclk) disable iff (!s_reset_n)
      reg_cs |-> !$isunknown({reg_wr, reg_addr, reg_be})
   );

endmodule

// ==== source/glbl_cfg_regs.sv ====
module glbl_cfg_regs #(
   parameter int unsigned NUM_SOFT_REGS = 8
) (
   input  logic                    mclk,
   input  logic                    s_reset_n,
   reg_access_if.target            acc,
   input  logic                    riscv_boot_mode,
   output glbl_reg_pkg::reg_word_t rst_ctrl,
   output glbl_reg_pkg::reg_word_t glbl_cfg,
   output glbl_reg_pkg::reg_word_t mux_sel,
   output glbl_reg_pkg::reg_word_t mbox_reg,
   output glbl_reg_pkg::reg_word_t soft_regs [NUM_SOFT_REGS]
);

   logic                    wr_en;
   glbl_reg_pkg::reg_word_t wr_mask;
   glbl_reg_pkg::reg_word_t wr_bits;

   // ------------------------------
   // Write qualifiers
   // ------------------------------
   assign wr_en   = acc.access & acc.wr;
   assign wr_mask = glbl_reg_pkg::be_mask(acc.be);
   // Enabled bytes of the write data
   assign wr_bits = acc.wdata & wr_mask;

   // ------------------------------
   // Configuration words
   // ------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         // Boot strap picks the reset release pattern
         rst_ctrl <= riscv_boot_mode ? glbl_reg_pkg::RST_CTRL_BOOT :
                                       glbl_reg_pkg::RST_CTRL_HOLD;
         glbl_cfg <= '0;
         mux_sel  <= glbl_reg_pkg::MUX_SEL_DEFAULT;
         mbox_reg <= '0;
      end else if (wr_en) begin
         // Only bytes with their enable set change
         case (acc.addr)
            glbl_reg_pkg::REG_RST_CTRL: begin
               rst_ctrl <= (rst_ctrl & ~wr_mask) | wr_bits;
            end
            glbl_reg_pkg::REG_GLBL_CFG: begin
               glbl_cfg <= (glbl_cfg & ~wr_mask) | wr_bits;
            end
            glbl_reg_pkg::REG_MUX_SEL: begin
               mux_sel <= (mux_sel & ~wr_mask) | wr_bits;
            end
            glbl_reg_pkg::REG_MAILBOX: begin
               mbox_reg <= (mbox_reg & ~wr_mask) | wr_bits;
            end
            default: begin
            end
         endcase
      end
   end

   // ------------------------------
   // Software scratch registers
   // ------------------------------
   // Slot i sits at REG_SOFT_0 + i
   // Slots beyond NUM_SOFT_REGS are unmapped
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         for (int i = 0; i < NUM_SOFT_REGS; i++) begin
            soft_regs[i] <= '0;
         end
      end else if (wr_en) begin
         for (int i = 0; i < NUM_SOFT_REGS; i++) begin
            if (acc.addr == glbl_reg_pkg::REG_SOFT_0 + i) begin
               soft_regs[i] <= (soft_regs[i] & ~wr_mask) | wr_bits;
            end
         end
      end
   end

endmodule

// ==== source/glbl_intr_ctrl.sv ====
module glbl_intr_ctrl (
   input  logic                    mclk,
   input  logic                    s_reset_n,
   reg_access_if.target            acc,
   input  logic [2:0]              timer_intr,
   input  logic                    i2cm_intr,
   input  logic                    usb_intr,
   input  logic                    pwm_intr,
   input  logic                    rtc_intr,
   input  logic                    ir_intr,
   input  logic [23:0]             gpio_intr,
   output glbl_reg_pkg::reg_word_t intr_mask,
   output glbl_reg_pkg::reg_word_t intr_stat,
   output glbl_reg_pkg::reg_word_t irq_lines
);

   glbl_reg_pkg::reg_word_t raw_req;
   glbl_reg_pkg::reg_word_t sync_q1;
   glbl_reg_pkg::reg_word_t sync_q2;
   glbl_reg_pkg::reg_word_t hw_req;
   glbl_reg_pkg::reg_word_t wr_mask;
   glbl_reg_pkg::reg_word_t sw_set;
   glbl_reg_pkg::reg_word_t sw_clr;
   logic                    wr_en;

   // ------------------------------
   // Hardware request vector
   // ------------------------------
   // GPIO 7 to 0 not available to software
   assign raw_req = {gpio_intr, ir_intr, rtc_intr, pwm_intr, usb_intr, i2cm_intr, timer_intr};

   // Two-flop sync on the foreign domain bits only
   // Other bits of these flops stay constant zero
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
      end else begin
         sync_q1 <= raw_req & glbl_reg_pkg::SYNC_INTR_MASK;
         sync_q2 <= sync_q1;
      end
   end

   assign hw_req = (raw_req & ~glbl_reg_pkg::SYNC_INTR_MASK) | sync_q2;

   // ------------------------------
   // Software set and clear
   // ------------------------------
   assign wr_en   = acc.access & acc.wr;
   assign wr_mask = glbl_reg_pkg::be_mask(acc.be);

   // Set address merges written ones into the request
   assign sw_set = (wr_en && acc.addr == glbl_reg_pkg::REG_INTR_SET) ?
                   (acc.wdata & wr_mask) : '0;
   // Write one to clear on the status address
   assign sw_clr = (wr_en && acc.addr == glbl_reg_pkg::REG_INTR_STAT) ?
                   (acc.wdata & wr_mask) : '0;

   // ------------------------------
   // Mask and sticky status
   // ------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         intr_mask <= '0;
      end else if (wr_en && acc.addr == glbl_reg_pkg::REG_INTR_MASK) begin
         intr_mask <= (intr_mask & ~wr_mask) | (acc.wdata & wr_mask);
      end
   end

   // Request wins over a clear in the same cycle
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         intr_stat <= '0;
      end else begin
         intr_stat <= (intr_stat & ~sw_clr) | hw_req | sw_set;
      end
   end

   // Pending and enabled lines to the core
   assign irq_lines = intr_mask & intr_stat;

   // Status bits drop only after a write to the status address
   stat_drop_needs_clear: assert property (
      @(posedge mclk) disable iff (!s_reset_n)
      (($past(intr_stat) & ~intr_stat) != '0) |->
         $past(acc.access && acc.wr && (acc.addr == glbl_reg_pkg::REG_INTR_STAT))
   );

endmodule

// ==== source/glbl_read_path.sv ====
module glbl_read_path #(
   parameter int unsigned NUM_SOFT_REGS = 8
) (
   input  logic                    mclk,
   input  logic                    s_reset_n,
   reg_access_if.target            acc,
   input  glbl_reg_pkg::reg_word_t rst_ctrl,
   input  glbl_reg_pkg::reg_word_t glbl_cfg,
   input  glbl_reg_pkg::reg_word_t mux_sel,
   input  glbl_reg_pkg::reg_word_t mbox_reg,
   input  glbl_reg_pkg::reg_word_t intr_mask,
   input  glbl_reg_pkg::reg_word_t intr_stat,
   input  glbl_reg_pkg::reg_word_t soft_regs [NUM_SOFT_REGS],
   output glbl_reg_pkg::reg_word_t reg_rdata
);

   glbl_reg_pkg::reg_word_t lfsr;
   glbl_reg_pkg::reg_word_t lfsr_next;
   glbl_reg_pkg::reg_word_t rd_mux;

   // ------------------------------
   // Random number generator
   // ------------------------------
   // Right-shifting Galois form
   assign lfsr_next = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? glbl_reg_pkg::LFSR_TAPS : '0);

   // ------------------------------
   // Read multiplexer
   // ------------------------------
   always_comb begin
      rd_mux = '0;
      case (acc.addr)
         glbl_reg_pkg::REG_CHIP_ID:   rd_mux = glbl_reg_pkg::CHIP_ID_WORD;
         glbl_reg_pkg::REG_RST_CTRL:  rd_mux = rst_ctrl;
         glbl_reg_pkg::REG_GLBL_CFG:  rd_mux = glbl_cfg;
         glbl_reg_pkg::REG_INTR_MASK: rd_mux = intr_mask;
         glbl_reg_pkg::REG_INTR_STAT: rd_mux = intr_stat;
         glbl_reg_pkg::REG_MUX_SEL:   rd_mux = mux_sel;
         glbl_reg_pkg::REG_RANDOM:    rd_mux = lfsr;
         // Set address reads back the status
         glbl_reg_pkg::REG_INTR_SET:  rd_mux = intr_stat;
         glbl_reg_pkg::REG_MAILBOX:   rd_mux = mbox_reg;
         default: begin
            // Populated software slots only
            for (int i = 0; i < NUM_SOFT_REGS; i++) begin
               if (acc.addr == glbl_reg_pkg::REG_SOFT_0 + i) begin
                  rd_mux = soft_regs[i];
               end
            end
         end
      endcase
   end

   // ------------------------------
   // Read data and LFSR advance
   // ------------------------------
   // Value is sampled before the step, reads and writes alike
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         reg_rdata <= '0;
         lfsr      <= glbl_reg_pkg::LFSR_SEED;
      end else if (acc.access) begin
         reg_rdata <= rd_mux;
         lfsr      <= lfsr_next;
      end
   end

   // Holes in the map and missing software slots return zero with ack
   unmapped_reads_zero: assert property (
      @(posedge mclk) disable iff (!s_reset_n)
      (acc.access && ((acc.addr inside {5'd6, 5'd7, 5'd8, [5'd11:5'd14]}) ||
                      (acc.addr >= glbl_reg_pkg::REG_SOFT_0 + NUM_SOFT_REGS)))
      |=> (reg_rdata == '0)
   );

endmodule

// ==== source/glbl_reg_top.sv ====
module glbl_reg_top #(
   parameter int unsigned NUM_SOFT_REGS = 8
) (
   input  logic                            mclk,
   input  logic                            s_reset_n,

   // Register bus
   input  logic                            reg_cs,
   input  logic                            reg_wr,
   input  logic [glbl_reg_pkg::ADDR_W-1:0] reg_addr,
   input  glbl_reg_pkg::reg_word_t         reg_wdata,
   input  glbl_reg_pkg::reg_be_t           reg_be,
   output glbl_reg_pkg::reg_word_t         reg_rdata,
   output logic                            reg_ack,

   input  logic                            riscv_boot_mode,

   // Interrupt sources
   input  logic [2:0]                      timer_intr,
   input  logic                            i2cm_intr,
   input  logic                            usb_intr,
   input  logic                            pwm_intr,
   input  logic                            rtc_intr,
   input  logic                            ir_intr,
   input  logic [23:0]                     gpio_intr,
   output glbl_reg_pkg::reg_word_t         irq_lines,

   // Block resets
   output logic [3:0]                      cpu_core_rst_n,
   output logic                            cpu_intf_rst_n,
   output logic                            qspim_rst_n,
   output logic                            sspim_rst_n,
   output logic [1:0]                      uart_rst_n,
   output logic                            i2cm_rst_n,
   output logic                            usb_rst_n,

   // Core and pin configuration
   output logic                            soft_irq,
   output logic [2:0]                      user_irq,
   output logic [15:0]                     cfg_riscv_ctrl,
   output logic                            cfg_gpio_dgmode,
   output glbl_reg_pkg::reg_word_t         cfg_multi_func_sel
);

   glbl_reg_pkg::reg_word_t rst_ctrl;
   glbl_reg_pkg::reg_word_t glbl_cfg;
   glbl_reg_pkg::reg_word_t mux_sel;
   glbl_reg_pkg::reg_word_t mbox_reg;
   glbl_reg_pkg::reg_word_t intr_mask;
   glbl_reg_pkg::reg_word_t intr_stat;
   glbl_reg_pkg::reg_word_t soft_regs [NUM_SOFT_REGS];

   reg_access_if u_acc ();

   glbl_bus_decode u_decode (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .reg_cs    (reg_cs),
      .reg_wr    (reg_wr),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_be    (reg_be),
      .reg_ack   (reg_ack),
      .acc       (u_acc.decoder)
   );

   glbl_cfg_regs #(.NUM_SOFT_REGS(NUM_SOFT_REGS)) u_cfg (
      .mclk            (mclk),
      .s_reset_n       (s_reset_n),
      .acc             (u_acc.target),
      .riscv_boot_mode (riscv_boot_mode),
      .rst_ctrl        (rst_ctrl),
      .glbl_cfg        (glbl_cfg),
      .mux_sel         (mux_sel),
      .mbox_reg        (mbox_reg),
      .soft_regs       (soft_regs)
   );

   glbl_intr_ctrl u_intr (
      .mclk       (mclk),
      .s_reset_n  (s_reset_n),
      .acc        (u_acc.target),
      .timer_intr (timer_intr),
      .i2cm_intr  (i2cm_intr),
      .usb_intr   (usb_intr),
      .pwm_intr   (pwm_intr),
      .rtc_intr   (rtc_intr),
      .ir_intr    (ir_intr),
      .gpio_intr  (gpio_intr),
      .intr_mask  (intr_mask),
      .intr_stat  (intr_stat),
      .irq_lines  (irq_lines)
   );

   glbl_read_path #(.NUM_SOFT_REGS(NUM_SOFT_REGS)) u_read (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .acc       (u_acc.target),
      .rst_ctrl  (rst_ctrl),
      .glbl_cfg  (glbl_cfg),
      .mux_sel   (mux_sel),
      .mbox_reg  (mbox_reg),
      .intr_mask (intr_mask),
      .intr_stat (intr_stat),
      .soft_regs (soft_regs),
      .reg_rdata (reg_rdata)
   );

   // ------------------------------
   // Reset control fields
   // ------------------------------
   // A one releases the block from reset
   assign cpu_intf_rst_n = rst_ctrl[0];
   assign qspim_rst_n    = rst_ctrl[1];
   assign sspim_rst_n    = rst_ctrl[2];
   assign uart_rst_n[0]  = rst_ctrl[3];
   assign i2cm_rst_n     = rst_ctrl[4];
   assign usb_rst_n      = rst_ctrl[5];
   assign uart_rst_n[1]  = rst_ctrl[6];
   // Bit 7 is spare
   assign cpu_core_rst_n = rst_ctrl[11:8];

   // ------------------------------
   // Configuration fields
   // ------------------------------
   assign user_irq           = glbl_cfg[2:0];
   assign soft_irq           = glbl_cfg[3];
   assign cfg_gpio_dgmode    = glbl_cfg[8];
   assign cfg_riscv_ctrl     = glbl_cfg[31:16];
   assign cfg_multi_func_sel = mux_sel;

endmodule

// ==== verification/glbl_reg_tb.sv ====
module glbl_reg_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned          NUM_SOFT_REGS = 8;
   localparam int unsigned          ACK_TIMEOUT   = 16;
   localparam int unsigned          IRQ_TIMEOUT   = 16;
   // Register bits that reach output pins
   localparam glbl_reg_pkg::reg_word_t CFG_PIN_BITS = 32'hFFFF_010F;
   localparam glbl_reg_pkg::reg_word_t RST_PIN_BITS = 32'h0000_0F7F;

   // One bus operation and the value it should return
   typedef struct {
      logic                    wr;
      logic [4:0]              addr;
      glbl_reg_pkg::reg_be_t   be;
      glbl_reg_pkg::reg_word_t wdata;
      glbl_reg_pkg::reg_word_t exp;
   } entry_t;

   logic                    mclk;
   logic                    s_reset_n;
   logic                    reg_cs;
   logic                    reg_wr;
   logic                    reg_ack;
   logic                    riscv_boot_mode;
   logic [4:0]              reg_addr;
   glbl_reg_pkg::reg_word_t reg_wdata;
   glbl_reg_pkg::reg_word_t reg_rdata;
   glbl_reg_pkg::reg_word_t irq_lines;
   glbl_reg_pkg::reg_word_t cfg_multi_func_sel;
   glbl_reg_pkg::reg_be_t   reg_be;
   logic [2:0]              timer_intr;
   logic [2:0]              user_irq;
   logic                    i2cm_intr;
   logic                    usb_intr;
   logic                    pwm_intr;
   logic                    rtc_intr;
   logic                    ir_intr;
   logic [23:0]             gpio_intr;
   logic [3:0]              cpu_core_rst_n;
   logic [1:0]              uart_rst_n;
   logic                    cpu_intf_rst_n;
   logic                    qspim_rst_n;
   logic                    sspim_rst_n;
   logic                    i2cm_rst_n;
   logic                    usb_rst_n;
   logic                    soft_irq;
   logic                    cfg_gpio_dgmode;
   logic [15:0]             cfg_riscv_ctrl;
   glbl_reg_pkg::reg_word_t cfg_pins;
   glbl_reg_pkg::reg_word_t rst_pins;
   glbl_reg_pkg::reg_word_t lfsr_model;
   entry_t                  stim_q[$];

   glbl_reg_top #(.NUM_SOFT_REGS(NUM_SOFT_REGS)) dut (.*);

   // Output pins packed back into register bit positions
   assign cfg_pins = {cfg_riscv_ctrl, 7'b0, cfg_gpio_dgmode, 4'b0, soft_irq, user_irq};
   assign rst_pins = {20'b0, cpu_core_rst_n, 1'b0, uart_rst_n[1], usb_rst_n, i2cm_rst_n,
                      uart_rst_n[0], sspim_rst_n, qspim_rst_n, cpu_intf_rst_n};

   initial begin
      mclk = 1'b0;
      forever #20 mclk = ~mclk;
   end

   // ------------------------------
   // Reference models
   // ------------------------------
   // Galois step, shift right and fold taps on a one out
   function automatic glbl_reg_pkg::reg_word_t lfsr_step(input glbl_reg_pkg::reg_word_t v);
      glbl_reg_pkg::reg_word_t n;
      n = v >> 1;
      if (v[0]) begin
         n = n ^ glbl_reg_pkg::LFSR_TAPS;
      end
      return n;
   endfunction

   function automatic glbl_reg_pkg::reg_word_t byte_mask(input glbl_reg_pkg::reg_be_t be);
      return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
   endfunction

   // ------------------------------
   // Checks
   // ------------------------------
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_word(input string name, input glbl_reg_pkg::reg_word_t exp,
                             input glbl_reg_pkg::reg_word_t act);
      if (act !== exp) begin
         abort_run($sformatf("error at %0t: %s expected %h actual %h", $time, name, exp, act));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         abort_run($sformatf("error at %0t: %s expected %b actual %b", $time, name, exp, act));
      end
   endtask

   task automatic check_irq(input glbl_reg_pkg::reg_word_t exp);
      check_word("irq_lines", exp, irq_lines);
   endtask

   // Only the wired reset bits are compared
   task automatic check_rst(input glbl_reg_pkg::reg_word_t exp);
      check_word("reset pins", exp & RST_PIN_BITS, rst_pins);
   endtask

   // ------------------------------
   // Bus and source drivers
   // ------------------------------
   // Every completed access also steps the LFSR model
   task automatic bus_access(input logic wr, input logic [4:0] addr,
                             input glbl_reg_pkg::reg_be_t be,
                             input glbl_reg_pkg::reg_word_t wdata,
                             output glbl_reg_pkg::reg_word_t rdata);
      int unsigned waited;
      waited = 0;
      @(negedge mclk);
      reg_cs    = 1'b1;
      reg_wr    = wr;
      reg_addr  = addr;
      reg_be    = be;
      reg_wdata = wdata;
      while (!reg_ack && waited < ACK_TIMEOUT) begin
         @(negedge mclk);
         waited++;
      end
      if (!reg_ack) begin
         abort_run("register bus never acknowledged the access");
      end else begin
         rdata      = reg_rdata;
         reg_cs     = 1'b0;
         reg_wr     = 1'b0;
         lfsr_model = lfsr_step(lfsr_model);
      end
   endtask

   task automatic write_reg(input logic [4:0] addr, input glbl_reg_pkg::reg_be_t be,
                            input glbl_reg_pkg::reg_word_t data);
      glbl_reg_pkg::reg_word_t unused;
      bus_access(1'b1, addr, be, data, unused);
   endtask

   task automatic read_check(input logic [4:0] addr, input glbl_reg_pkg::reg_word_t exp);
      glbl_reg_pkg::reg_word_t rdata;
      bus_access(1'b0, addr, 4'hF, '0, rdata);
      check_word($sformatf("reg_rdata[%0d]", addr), exp, rdata);
   endtask

   // One-cycle pulse on the sources in status bit order
   task automatic pulse_sources(input glbl_reg_pkg::reg_word_t pat);
      @(negedge mclk);
      {gpio_intr, ir_intr, rtc_intr, pwm_intr, usb_intr, i2cm_intr, timer_intr} = pat;
      @(negedge mclk);
      {gpio_intr, ir_intr, rtc_intr, pwm_intr, usb_intr, i2cm_intr, timer_intr} = '0;
   endtask

   task automatic wait_irq(input glbl_reg_pkg::reg_word_t exp);
      int unsigned waited;
      waited = 0;
      while (irq_lines !== exp && waited < IRQ_TIMEOUT) begin
         @(negedge mclk);
         waited++;
      end
      check_irq(exp);
   endtask

   // ------------------------------
   // Stimulus table
   // ------------------------------
   task automatic add_entry(input logic wr, input logic [4:0] addr,
                            input glbl_reg_pkg::reg_be_t be,
                            input glbl_reg_pkg::reg_word_t wdata,
                            input glbl_reg_pkg::reg_word_t exp);
      entry_t e;
      e.wr    = wr;
      e.addr  = addr;
      e.be    = be;
      e.wdata = wdata;
      e.exp   = exp;
      stim_q.push_back(e);
   endtask

   // Shadow copy of the register map tracks expected contents
   task automatic build_table();
      glbl_reg_pkg::reg_word_t shadow [32];
      glbl_reg_pkg::reg_word_t data;
      glbl_reg_pkg::reg_be_t   be;
      logic [4:0]              wr_addrs [10];
      logic [4:0]              a;
      shadow = '{default: '0};
      shadow[glbl_reg_pkg::REG_CHIP_ID]  = glbl_reg_pkg::CHIP_ID_WORD;
      shadow[glbl_reg_pkg::REG_RST_CTRL] = glbl_reg_pkg::RST_CTRL_BOOT;
      shadow[glbl_reg_pkg::REG_MUX_SEL]  = glbl_reg_pkg::MUX_SEL_DEFAULT;
      // Reset values
      foreach (shadow[i]) begin
         if (i <= 5 || i >= 15 && i <= 23) begin
            add_entry(1'b0, 5'(i), 4'hF, '0, shadow[i]);
         end
      end
      // Partial writes, mailbox and config first
      wr_addrs[0] = glbl_reg_pkg::REG_MAILBOX;
      wr_addrs[1] = glbl_reg_pkg::REG_GLBL_CFG;
      for (int i = 0; i < 8; i++) begin
         wr_addrs[i + 2] = 5'(glbl_reg_pkg::REG_SOFT_0 + i);
      end
      foreach (wr_addrs[i]) begin
         a         = wr_addrs[i];
         data      = $urandom;
         be        = 4'($urandom);
         shadow[a] = (shadow[a] & ~byte_mask(be)) | (data & byte_mask(be));
         add_entry(1'b1, a, be, data, shadow[a]);
         add_entry(1'b0, a, 4'hF, '0, shadow[a]);
      end
      // Holes in the map
      for (int i = 11; i < 32; i++) begin
         if (i == 11 || i >= 24) begin
            add_entry(1'b1, 5'(i), 4'hF, $urandom, '0);
            add_entry(1'b0, 5'(i), 4'hF, '0, '0);
         end
      end
      // Full sweep, random address takes the model value at run time
      foreach (shadow[i]) begin
         add_entry(1'b0, 5'(i), 4'hF, '0, shadow[i]);
      end
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial begin
      entry_t                  e;
      glbl_reg_pkg::reg_word_t exp;
      glbl_reg_pkg::reg_word_t rdata;
      glbl_reg_pkg::reg_word_t data;
      glbl_reg_pkg::reg_word_t mask_model;
      glbl_reg_pkg::reg_word_t stat_model;
      glbl_reg_pkg::reg_be_t   be;
      void'($urandom(32'hbcd1));
      s_reset_n       = 1'b0;
      reg_cs          = 1'b0;
      reg_wr          = 1'b0;
      reg_addr        = '0;
      reg_wdata       = '0;
      reg_be          = '0;
      riscv_boot_mode = 1'b1;
      {gpio_intr, ir_intr, rtc_intr, pwm_intr, usb_intr, i2cm_intr, timer_intr} = '0;
      lfsr_model = glbl_reg_pkg::LFSR_SEED;
      repeat (3) @(posedge mclk);
      @(negedge mclk);
      s_reset_n = 1'b1;
      check_bit("reg_ack", 1'b0, reg_ack);
      check_irq('0);
      check_rst(glbl_reg_pkg::RST_CTRL_BOOT);

      build_table();
      foreach (stim_q[n]) begin
         e   = stim_q[n];
         exp = (e.addr == glbl_reg_pkg::REG_RANDOM) ? lfsr_model : e.exp;
         bus_access(e.wr, e.addr, e.be, e.wdata, rdata);
         if (!e.wr) begin
            check_word($sformatf("reg_rdata[%0d]", e.addr), exp, rdata);
         end else if (e.addr == glbl_reg_pkg::REG_GLBL_CFG) begin
            check_word("cfg pins", e.exp & CFG_PIN_BITS, cfg_pins);
         end
      end
      check_rst(glbl_reg_pkg::RST_CTRL_BOOT);
      check_word("cfg_multi_func_sel", glbl_reg_pkg::MUX_SEL_DEFAULT, cfg_multi_func_sel);

      // Hardware sources, sticky until cleared
      mask_model = $urandom;
      stat_model = '0;
      write_reg(glbl_reg_pkg::REG_INTR_MASK, 4'hF, mask_model);
      read_check(glbl_reg_pkg::REG_INTR_MASK, mask_model);
      repeat (6) begin
         data = $urandom & $urandom;
         pulse_sources(data);
         stat_model = stat_model | data;
         // Synchronized bits land three cycles after the rise
         repeat (2) @(negedge mclk);
         wait_irq(mask_model & stat_model);
         read_check(glbl_reg_pkg::REG_INTR_STAT, stat_model);
      end

      // Write one to clear
      repeat (4) begin
         data = $urandom;
         be   = 4'($urandom);
         write_reg(glbl_reg_pkg::REG_INTR_STAT, be, data);
         stat_model = stat_model & ~(data & byte_mask(be));
         check_irq(mask_model & stat_model);
         read_check(glbl_reg_pkg::REG_INTR_STAT, stat_model);
      end

      // Software set, readable at the set address
      repeat (4) begin
         data = $urandom & $urandom;
         be   = 4'($urandom);
         write_reg(glbl_reg_pkg::REG_INTR_SET, be, data);
         stat_model = stat_model | (data & byte_mask(be));
         check_irq(mask_model & stat_model);
         read_check(glbl_reg_pkg::REG_INTR_SET, stat_model);
         read_check(glbl_reg_pkg::REG_INTR_STAT, stat_model);
      end

      // Generator after many mixed accesses
      repeat (4) begin
         read_check(glbl_reg_pkg::REG_RANDOM, lfsr_model);
      end

      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== filelist.f ====
source/glbl_reg_pkg.sv
source/reg_access_if.sv
source/glbl_bus_decode.sv
source/glbl_cfg_regs.sv
source/glbl_intr_ctrl.sv
source/glbl_read_path.sv
source/glbl_reg_top.sv
verification/glbl_reg_tb.sv

// ==== Bender.yml ====
package:
  name: glbl_reg

sources:
  - source/glbl_reg_pkg.sv
  - source/reg_access_if.sv
  - source/glbl_bus_decode.sv
  - source/glbl_cfg_regs.sv
  - source/glbl_intr_ctrl.sv
  - source/glbl_read_path.sv
  - source/glbl_reg_top.sv
  - target: test
    files:
      - verification/glbl_reg_tb.sv
